// ==== Makefile ====
# Verilator build and run of the L2 cache slice testbench

VERILATOR ?= verilator
TOP ?= l2_cache_tb
BUILD_DIR ?= obj_dir
FILE_LIST ?= build.f
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(wildcard source/*.sv source/*.svh test/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
+incdir+source
source/l2_pkg.sv
source/l2_way_array.sv
source/l2_cache_tag.sv
source/l2_cache_update.sv
source/l2_cache_slice.sv
test/l2_cache_tb.sv

// ==== source/l2_cache_slice.sv ====
// No back-pressure; outputs pulse two cycles after req_valid and every pulse must be taken
`include "l2_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module l2_cache_slice
	import l2_pkg::*;
(
	input logic clk,
	input logic reset,

	// Core request, or fill with the original request
	input logic req_valid,
	input l2req_type_t req_type,
	input logic [`CORE_ID_WIDTH - 1:0] req_core,
	input logic [`REQ_ID_WIDTH - 1:0] req_id,
	input logic [`L2_ADDR_WIDTH - 1:0] req_address,
	input store_mask_t req_store_mask,
	input cache_line_t req_data,
	input logic req_is_fill,
	input cache_line_t req_fill_data,

	// Response
	output logic rsp_valid,
	output l2rsp_type_t rsp_type,
	output logic [`CORE_ID_WIDTH - 1:0] rsp_core,
	output logic [`REQ_ID_WIDTH - 1:0] rsp_id,
	output logic [`L2_ADDR_WIDTH - 1:0] rsp_address,
	output cache_line_t rsp_data,

	// Miss
	output logic miss_valid,
	output logic [`L2_ADDR_WIDTH - 1:0] miss_address,

	// Writeback
	output logic wb_valid,
	output logic [`L2_ADDR_WIDTH - 1:0] wb_address,
	output cache_line_t wb_data
);

	// Tag stage to update stage
	logic tr_valid;
	l2req_type_t tr_type;
	logic [`CORE_ID_WIDTH - 1:0] tr_core;
	logic [`REQ_ID_WIDTH - 1:0] tr_id;
	logic [`L2_ADDR_WIDTH - 1:0] tr_address;
	store_mask_t tr_store_mask;
	cache_line_t tr_data;
	logic tr_is_fill;
	cache_line_t tr_fill_data;
	logic tr_hit;
	l2_way_t tr_way;
	logic tr_victim_valid;
	logic tr_victim_dirty;
	l2_tag_t tr_victim_tag;

	// Data array ports
	cache_line_t [`L2_WAYS - 1:0] way_lines;
	logic data_write_en;
	l2_set_t data_write_set;
	l2_way_t data_write_way;
	cache_line_t data_write_line;

	l2_cache_tag u_tag (
		.clk(clk), .reset(reset),
		.req_valid(req_valid), .req_type(req_type), .req_core(req_core), .req_id(req_id),
		.req_address(req_address), .req_store_mask(req_store_mask), .req_data(req_data),
		.req_is_fill(req_is_fill), .req_fill_data(req_fill_data),
		.tr_valid(tr_valid), .tr_type(tr_type), .tr_core(tr_core), .tr_id(tr_id),
		.tr_address(tr_address), .tr_store_mask(tr_store_mask), .tr_data(tr_data),
		.tr_is_fill(tr_is_fill), .tr_fill_data(tr_fill_data),
		.tr_hit(tr_hit), .tr_way(tr_way), .tr_victim_valid(tr_victim_valid),
		.tr_victim_dirty(tr_victim_dirty), .tr_victim_tag(tr_victim_tag)
	);

	// Lines read in parallel with the tag lookup
	l2_way_array #(
		.entry_t(cache_line_t)
	) u_data (
		.clk(clk), .reset(reset),
		.read_en(req_valid), .read_set(req_address[`L2_SET_BITS - 1:0]),
		.read_entries(way_lines),
		.write_en(data_write_en), .write_set(data_write_set),
		.write_way(data_write_way), .write_entry(data_write_line)
	);

	l2_cache_update u_update (
		.clk(clk), .reset(reset),
		.tr_valid(tr_valid), .tr_type(tr_type), .tr_core(tr_core), .tr_id(tr_id),
		.tr_address(tr_address), .tr_store_mask(tr_store_mask), .tr_data(tr_data),
		.tr_is_fill(tr_is_fill), .tr_fill_data(tr_fill_data),
		.tr_hit(tr_hit), .tr_way(tr_way), .tr_victim_valid(tr_victim_valid),
		.tr_victim_dirty(tr_victim_dirty), .tr_victim_tag(tr_victim_tag),
		.way_lines(way_lines),
		.data_write_en(data_write_en), .data_write_set(data_write_set),
		.data_write_way(data_write_way), .data_write_line(data_write_line),
		.rsp_valid(rsp_valid), .rsp_type(rsp_type), .rsp_core(rsp_core), .rsp_id(rsp_id),
		.rsp_address(rsp_address), .rsp_data(rsp_data),
		.miss_valid(miss_valid), .miss_address(miss_address),
		.wb_valid(wb_valid), .wb_address(wb_address), .wb_data(wb_data)
	);

endmodule

`default_nettype wire

// ==== source/l2_cache_tag.sv ====
// One request per cycle, one cycle latency; a fill must not hit, victim outputs describe tr_way
`include "l2_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module l2_cache_tag
	import l2_pkg::*;
(
	input logic clk,
	input logic reset,

	// Request from the cores
	input logic req_valid,
	input l2req_type_t req_type,
	input logic [`CORE_ID_WIDTH - 1:0] req_core,
	input logic [`REQ_ID_WIDTH - 1:0] req_id,
	input logic [`L2_ADDR_WIDTH - 1:0] req_address,
	input store_mask_t req_store_mask,
	input cache_line_t req_data,
	input logic req_is_fill,
	input cache_line_t req_fill_data,

	// Registered request to the update stage
	output logic tr_valid,
	output l2req_type_t tr_type,
	output logic [`CORE_ID_WIDTH - 1:0] tr_core,
	output logic [`REQ_ID_WIDTH - 1:0] tr_id,
	output logic [`L2_ADDR_WIDTH - 1:0] tr_address,
	output store_mask_t tr_store_mask,
	output cache_line_t tr_data,
	output logic tr_is_fill,
	output cache_line_t tr_fill_data,

	// Lookup result
	output logic tr_hit,
	output l2_way_t tr_way,
	output logic tr_victim_valid,
	output logic tr_victim_dirty,
	output l2_tag_t tr_victim_tag
);

	tag_entry_t [`L2_WAYS - 1:0] tag_entries;
	logic [`L2_WAYS - 1:0] hit_ways;
	l2_way_t hit_way;
	l2_way_t victim_way;
	logic all_valid;
	l2_way_t rr_ptr [`L2_SETS];
	l2_set_t tr_set;
	l2_tag_t tr_tag;
	tag_entry_t cur_entry;
	tag_entry_t new_entry;
	logic tag_write_en;

	// Control bit resets, payload just follows the strobe
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			tr_valid <= 1'b0;
		else
			tr_valid <= req_valid;
	end

	always_ff @(posedge clk)
	begin
		if (req_valid)
		begin
			tr_type <= req_type;
			tr_core <= req_core;
			tr_id <= req_id;
			tr_address <= req_address;
			tr_store_mask <= req_store_mask;
			tr_data <= req_data;
			tr_is_fill <= req_is_fill;
			tr_fill_data <= req_fill_data;
		end
	end

	assign tr_set = tr_address[`L2_SET_BITS - 1:0];
	assign tr_tag = tr_address[`L2_ADDR_WIDTH - 1:`L2_SET_BITS];

	// Tag entries read alongside the request register
	l2_way_array #(
		.entry_t(tag_entry_t)
	) u_tag_array (
		.clk(clk),
		.reset(reset),
		.read_en(req_valid),
		.read_set(req_address[`L2_SET_BITS - 1:0]),
		.read_entries(tag_entries),
		.write_en(tag_write_en),
		.write_set(tr_set),
		.write_way(tr_way),
		.write_entry(new_entry)
	);

	// Compare all ways at once
	always_comb
	begin
		hit_way = '0;
		for (int w = 0; w < `L2_WAYS; w++)
		begin
			hit_ways[w] = tag_entries[w].valid && tag_entries[w].tag == tr_tag;
			if (hit_ways[w])
				hit_way = l2_way_t'(w);
		end
	end

	assign tr_hit = |hit_ways;

	// Lowest invalid way wins; scan downward so the last match is the lowest
	always_comb
	begin
		victim_way = rr_ptr[tr_set];
		all_valid = 1'b1;
		for (int w = `L2_WAYS - 1; w >= 0; w--)
		begin
			if (!tag_entries[w].valid)
			begin
				victim_way = l2_way_t'(w);
				all_valid = 1'b0;
			end
		end
	end

	assign tr_way = tr_is_fill ? victim_way : hit_way;

	// Old state of the selected way, victim on a fill, hit way otherwise
	assign cur_entry = tag_entries[tr_way];
	assign tr_victim_valid = cur_entry.valid;
	assign tr_victim_dirty = cur_entry.dirty;
	assign tr_victim_tag = cur_entry.tag;

	// Next tag state for the selected way
	always_comb
	begin
		new_entry = cur_entry;
		tag_write_en = 1'b0;
		if (tr_valid && tr_is_fill)
		begin
			new_entry.valid = 1'b1;
			new_entry.dirty = tr_type == L2REQ_STORE;
			new_entry.tag = tr_tag;
			tag_write_en = 1'b1;
		end
		else if (tr_valid && tr_hit)
		begin
			case (tr_type)
				L2REQ_STORE:
				begin
					new_entry.dirty = 1'b1;
					tag_write_en = 1'b1;
				end

				L2REQ_FLUSH:
				begin
					new_entry.dirty = 1'b0;
					tag_write_en = 1'b1;
				end

				L2REQ_DINVALIDATE:
				begin
					new_entry.valid = 1'b0;
					tag_write_en = 1'b1;
				end

				default:
					tag_write_en = 1'b0;
			endcase
		end
	end

	// Round-robin only moves when a full set is replaced
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < `L2_SETS; s++)
				rr_ptr[s] <= '0;
		end
		else if (tr_valid && tr_is_fill && all_valid)
			rr_ptr[tr_set] <= rr_ptr[tr_set] + 1'b1;
	end

	// A line lives in one way only, fills install with no duplicate
	single_hit: assert property (
		@(posedge clk) disable iff (reset)
		tr_valid |-> $onehot0(hit_ways))
		else $error("l2_cache_tag multiple ways hit");

	fill_misses: assert property (
		@(posedge clk) disable iff (reset)
		tr_valid && tr_is_fill |-> !tr_hit)
		else $error("l2_cache_tag fill hit an existing line");

endmodule

`default_nettype wire

// ==== source/l2_cache_update.sv ====
// Data write is combinational in the lookup cycle; response, miss and writeback are one-cycle pulses
`include "l2_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module l2_cache_update
	import l2_pkg::*;
(
	input logic clk,
	input logic reset,

	// From the tag stage
	input logic tr_valid,
	input l2req_type_t tr_type,
	input logic [`CORE_ID_WIDTH - 1:0] tr_core,
	input logic [`REQ_ID_WIDTH - 1:0] tr_id,
	input logic [`L2_ADDR_WIDTH - 1:0] tr_address,
	input store_mask_t tr_store_mask,
	input cache_line_t tr_data,
	input logic tr_is_fill,
	input cache_line_t tr_fill_data,
	input logic tr_hit,
	input l2_way_t tr_way,
	input logic tr_victim_valid,
	input logic tr_victim_dirty,
	input l2_tag_t tr_victim_tag,

	// From the data array
	input cache_line_t [`L2_WAYS - 1:0] way_lines,

	// Data array write
	output logic data_write_en,
	output l2_set_t data_write_set,
	output l2_way_t data_write_way,
	output cache_line_t data_write_line,

	// Response to the core
	output logic rsp_valid,
	output l2rsp_type_t rsp_type,
	output logic [`CORE_ID_WIDTH - 1:0] rsp_core,
	output logic [`REQ_ID_WIDTH - 1:0] rsp_id,
	output logic [`L2_ADDR_WIDTH - 1:0] rsp_address,
	output cache_line_t rsp_data,

	// Miss request to memory
	output logic miss_valid,
	output logic [`L2_ADDR_WIDTH - 1:0] miss_address,

	// Dirty line leaving the cache
	output logic wb_valid,
	output logic [`L2_ADDR_WIDTH - 1:0] wb_address,
	output cache_line_t wb_data
);

	cache_line_t old_line;
	cache_line_t base_line;
	cache_line_t merged_line;
	logic is_store;
	logic send_rsp;
	logic send_miss;
	logic send_wb;
	l2rsp_type_t rsp_kind;
	l2_set_t tr_set;

	assign tr_set = tr_address[`L2_SET_BITS - 1:0];
	assign is_store = tr_type == L2REQ_STORE;

	// Line currently in the selected way, also the writeback payload
	assign old_line = way_lines[tr_way];
	assign base_line = tr_is_fill ? tr_fill_data : old_line;

	// Byte merge of the store data
	always_comb
	begin
		merged_line = base_line;
		if (is_store)
		begin
			for (int b = 0; b < `CACHE_LINE_BYTES; b++)
			begin
				if (tr_store_mask[b])
					merged_line[b * 8 +: 8] = tr_data[b * 8 +: 8];
			end
		end
	end

	// Fills always install, stores only on hit
	assign data_write_en = tr_valid && (tr_is_fill || (tr_hit && is_store));
	assign data_write_set = tr_set;
	assign data_write_way = tr_way;
	assign data_write_line = merged_line;

	// Ack kind follows the request, fills keep their original kind
	always_comb
	begin
		case (tr_type)
			L2REQ_LOAD: rsp_kind = L2RSP_LOAD_ACK;
			L2REQ_STORE: rsp_kind = L2RSP_STORE_ACK;
			L2REQ_FLUSH: rsp_kind = L2RSP_FLUSH_ACK;
			L2REQ_DINVALIDATE: rsp_kind = L2RSP_DINVALIDATE_ACK;
			L2REQ_IINVALIDATE: rsp_kind = L2RSP_IINVALIDATE_ACK;
			default: rsp_kind = L2RSP_LOAD_ACK;
		endcase
	end

	// Only load and store misses wait for memory
	assign send_miss = tr_valid && !tr_is_fill && !tr_hit
		&& (tr_type == L2REQ_LOAD || is_store);

	// Hits, fills and maintenance requests answer at once
	assign send_rsp = tr_valid && (tr_is_fill || tr_hit || tr_type == L2REQ_FLUSH
		|| tr_type == L2REQ_DINVALIDATE || tr_type == L2REQ_IINVALIDATE);

	// Dirty victim on a fill, or a dirty line hit by a flush
	assign send_wb = tr_valid && tr_victim_valid && tr_victim_dirty
		&& (tr_is_fill || (tr_hit && tr_type == L2REQ_FLUSH));

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rsp_valid <= 1'b0;
			miss_valid <= 1'b0;
			wb_valid <= 1'b0;
		end
		else
		begin
			rsp_valid <= send_rsp;
			miss_valid <= send_miss;
			wb_valid <= send_wb;
		end
	end

	// Payloads qualified by the valid pulses above
	always_ff @(posedge clk)
	begin
		rsp_type <= rsp_kind;
		rsp_core <= tr_core;
		rsp_id <= tr_id;
		rsp_address <= tr_address;
		rsp_data <= (tr_hit || tr_is_fill) ? merged_line : '0;
		miss_address <= tr_address;
		// Victim address rebuilt from its tag and this set
		wb_address <= {tr_victim_tag, tr_set};
		wb_data <= old_line;
	end

	// A request is either answered or sent to memory, never both
	rsp_or_miss: assert property (
		@(posedge clk) disable iff (reset)
		!(rsp_valid && miss_valid))
		else $error("l2_cache_update response and miss together");

endmodule

`default_nettype wire

// ==== source/l2_defines.svh ====
// Sizes are fixed at 4 ways, 16 sets and 16-byte lines; set and way counts must be powers of two
`ifndef L2_DEFINES_SVH
`define L2_DEFINES_SVH

`default_nettype none

// Associativity and number of sets in the single bank
`define L2_WAYS 4
`define L2_SETS 16

// Bytes held by one cache line
`define CACHE_LINE_BYTES 16

// Requests carry line addresses, not byte addresses
`define L2_ADDR_WIDTH 26

// Identify the requesting core and the request within that core
`define CORE_ID_WIDTH 2
`define REQ_ID_WIDTH 2

// Derived index widths
`define L2_SET_BITS $clog2(`L2_SETS)
`define L2_WAY_BITS $clog2(`L2_WAYS)

// Tag holds the line address bits above the set index
`define L2_TAG_WIDTH (`L2_ADDR_WIDTH - `L2_SET_BITS)

`default_nettype wire

`endif

// ==== source/l2_pkg.sv ====
// Request and response encodings are 3 bits wide; only five kinds of each are defined
`include "l2_defines.svh"

`default_nettype none

package l2_pkg;

	// Kinds of request a core may send
	typedef enum logic [2:0]
	{
		L2REQ_LOAD,
		L2REQ_STORE,
		L2REQ_FLUSH,
		L2REQ_DINVALIDATE,
		L2REQ_IINVALIDATE
	} l2req_type_t;

	// Acknowledge kinds, one per request kind
	typedef enum logic [2:0]
	{
		L2RSP_LOAD_ACK,
		L2RSP_STORE_ACK,
		L2RSP_FLUSH_ACK,
		L2RSP_DINVALIDATE_ACK,
		L2RSP_IINVALIDATE_ACK
	} l2rsp_type_t;

	// Line payload, byte 0 in the low bits
	typedef logic [`CACHE_LINE_BYTES * 8 - 1:0] cache_line_t;

	// One enable per byte of the line
	typedef logic [`CACHE_LINE_BYTES - 1:0] store_mask_t;

	// Address fields
	typedef logic [`L2_TAG_WIDTH - 1:0] l2_tag_t;
	typedef logic [`L2_SET_BITS - 1:0] l2_set_t;
	typedef logic [`L2_WAY_BITS - 1:0] l2_way_t;

	// Per-way state kept in the tag array
	typedef struct packed
	{
		logic valid;
		logic dirty;
		l2_tag_t tag;
	} tag_entry_t;

endpackage

`default_nettype wire

// ==== source/l2_way_array.sv ====
// Storage is reset to zero, so entries start invalid; one write and one set read per cycle
`include "l2_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module l2_way_array
	import l2_pkg::*;
#(
	parameter type entry_t = logic [7:0]
)
(
	input logic clk,
	input logic reset,

	// Read side, all ways of one set
	input logic read_en,
	input l2_set_t read_set,
	output entry_t [`L2_WAYS - 1:0] read_entries,

	// Write side, one way of one set
	input logic write_en,
	input l2_set_t write_set,
	input l2_way_t write_way,
	input entry_t write_entry
);

	// Sets by ways
	entry_t storage [`L2_SETS][`L2_WAYS];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < `L2_SETS; s++)
			begin
				for (int w = 0; w < `L2_WAYS; w++)
					storage[s][w] <= '0;
			end

			read_entries <= '0;
		end
		else
		begin
			if (write_en)
				storage[write_set][write_way] <= write_entry;

			if (read_en)
			begin
				for (int w = 0; w < `L2_WAYS; w++)
				begin
					// Write-first: a write landing on the set being read wins
					if (write_en && write_set == read_set && write_way == l2_way_t'(w))
						read_entries[w] <= write_entry;
					else
						read_entries[w] <= storage[read_set][w];
				end
			end
		end
	end

	// Way select must be resolved whenever a write is issued
	write_way_known: assert property (
		@(posedge clk) disable iff (reset)
		write_en |-> !$isunknown(write_way))
		else $error("l2_way_array write with unknown way");

endmodule

`default_nettype wire

// ==== test/l2_cache_tb.sv ====
// Fills are only sent for lines absent from the cache; every output is checked two cycles after issue
`include "l2_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module l2_cache_tb
	import l2_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 200;
	localparam int RANDOM_REQUESTS = 400;

	typedef logic [`CORE_ID_WIDTH - 1:0] core_id_t;
	typedef logic [`REQ_ID_WIDTH - 1:0] req_id_t;
	typedef logic [`L2_ADDR_WIDTH - 1:0] line_addr_t;

	// Expected outputs of one request, due two cycles after issue
	typedef struct packed
	{
		logic [31:0] due;
		logic rsp_valid;
		l2rsp_type_t rsp_type;
		core_id_t rsp_core;
		req_id_t rsp_id;
		line_addr_t rsp_address;
		cache_line_t rsp_data;
		logic miss_valid;
		line_addr_t miss_address;
		logic wb_valid;
		line_addr_t wb_address;
		cache_line_t wb_data;
	} expect_t;

	logic clk;
	logic reset;

	// DUT inputs
	logic req_valid;
	l2req_type_t req_type;
	core_id_t req_core;
	req_id_t req_id;
	line_addr_t req_address;
	store_mask_t req_store_mask;
	cache_line_t req_data;
	logic req_is_fill;
	cache_line_t req_fill_data;

	// DUT outputs
	logic rsp_valid;
	l2rsp_type_t rsp_type;
	core_id_t rsp_core;
	req_id_t rsp_id;
	line_addr_t rsp_address;
	cache_line_t rsp_data;
	logic miss_valid;
	line_addr_t miss_address;
	logic wb_valid;
	line_addr_t wb_address;
	cache_line_t wb_data;

	// Predictions in issue order, consumed by the checker through an index
	expect_t expect_q[$];
	expect_t due_entry;
	int check_index = 0;
	logic [31:0] cycle = '0;
	int failures = 0;

	// Reference cache state
	logic model_valid [`L2_SETS][`L2_WAYS];
	logic model_dirty [`L2_SETS][`L2_WAYS];
	l2_tag_t model_tag [`L2_SETS][`L2_WAYS];
	cache_line_t model_line [`L2_SETS][`L2_WAYS];
	l2_way_t model_rr [`L2_SETS];

	l2_cache_slice u_l2_cache_slice (
		.clk(clk), .reset(reset),
		.req_valid(req_valid), .req_type(req_type), .req_core(req_core), .req_id(req_id),
		.req_address(req_address), .req_store_mask(req_store_mask), .req_data(req_data),
		.req_is_fill(req_is_fill), .req_fill_data(req_fill_data),
		.rsp_valid(rsp_valid), .rsp_type(rsp_type), .rsp_core(rsp_core), .rsp_id(rsp_id),
		.rsp_address(rsp_address), .rsp_data(rsp_data),
		.miss_valid(miss_valid), .miss_address(miss_address),
		.wb_valid(wb_valid), .wb_address(wb_address), .wb_data(wb_data)
	);

	// 40 ns period
	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 32'd1;

	function automatic line_addr_t make_address(input l2_tag_t tag, input l2_set_t set);
		return {tag, set};
	endfunction

	function automatic cache_line_t random_line();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	// Byte 0 sits in the low bits of the line
	function automatic cache_line_t merge_bytes(input cache_line_t base, input cache_line_t data,
		input store_mask_t mask);
		cache_line_t result;
		result = base;
		for (int b = 0; b < `CACHE_LINE_BYTES; b++)
		begin
			if (mask[b])
				result[b * 8 +: 8] = data[b * 8 +: 8];
		end
		return result;
	endfunction

	function automatic l2rsp_type_t ack_for(input l2req_type_t kind);
		case (kind)
			L2REQ_STORE: return L2RSP_STORE_ACK;
			L2REQ_FLUSH: return L2RSP_FLUSH_ACK;
			L2REQ_DINVALIDATE: return L2RSP_DINVALIDATE_ACK;
			L2REQ_IINVALIDATE: return L2RSP_IINVALIDATE_ACK;
			default: return L2RSP_LOAD_ACK;
		endcase
	endfunction

	function automatic logic line_present(input line_addr_t address);
		logic found;
		found = 1'b0;
		for (int w = 0; w < `L2_WAYS; w++)
		begin
			if (model_valid[address[`L2_SET_BITS - 1:0]][w]
				&& model_tag[address[`L2_SET_BITS - 1:0]][w]
				== address[`L2_ADDR_WIDTH - 1:`L2_SET_BITS])
				found = 1'b1;
		end
		return found;
	endfunction

	// Expected outputs for one request, updating the model as the cache would
	function automatic expect_t l2_predict(input l2req_type_t kind, input core_id_t core,
		input req_id_t id, input line_addr_t address, input store_mask_t mask,
		input cache_line_t data, input logic is_fill, input cache_line_t fill_data);
		expect_t e;
		l2_set_t set;
		l2_tag_t tag;
		l2_way_t way;
		logic hit;
		logic found;
		cache_line_t line;

		e = '0;
		set = address[`L2_SET_BITS - 1:0];
		tag = address[`L2_ADDR_WIDTH - 1:`L2_SET_BITS];
		way = '0;
		hit = 1'b0;
		found = 1'b0;
		e.rsp_type = ack_for(kind);
		e.rsp_core = core;
		e.rsp_id = id;
		e.rsp_address = address;
		e.miss_address = address;

		for (int w = 0; w < `L2_WAYS; w++)
		begin
			if (model_valid[set][w] && model_tag[set][w] == tag)
			begin
				hit = 1'b1;
				way = l2_way_t'(w);
			end
		end

		if (is_fill)
		begin
			// Lowest invalid way first, round-robin once the set is full
			for (int w = 0; w < `L2_WAYS; w++)
			begin
				if (!found && !model_valid[set][w])
				begin
					way = l2_way_t'(w);
					found = 1'b1;
				end
			end
			if (!found)
			begin
				way = model_rr[set];
				model_rr[set] = model_rr[set] + l2_way_t'(1);
			end
			if (model_valid[set][way] && model_dirty[set][way])
			begin
				e.wb_valid = 1'b1;
				e.wb_address = make_address(model_tag[set][way], set);
				e.wb_data = model_line[set][way];
			end
			line = (kind == L2REQ_STORE) ? merge_bytes(fill_data, data, mask) : fill_data;
			model_line[set][way] = line;
			model_valid[set][way] = 1'b1;
			model_dirty[set][way] = kind == L2REQ_STORE;
			model_tag[set][way] = tag;
			e.rsp_valid = 1'b1;
			e.rsp_data = line;
		end
		else if (!hit && (kind == L2REQ_LOAD || kind == L2REQ_STORE))
			e.miss_valid = 1'b1;
		else
		begin
			e.rsp_valid = 1'b1;
			if (hit)
			begin
				line = model_line[set][way];
				case (kind)
					L2REQ_STORE:
					begin
						line = merge_bytes(line, data, mask);
						model_line[set][way] = line;
						model_dirty[set][way] = 1'b1;
					end

					L2REQ_FLUSH:
					begin
						if (model_dirty[set][way])
						begin
							e.wb_valid = 1'b1;
							e.wb_address = address;
							e.wb_data = line;
						end
						model_dirty[set][way] = 1'b0;
					end

					L2REQ_DINVALIDATE:
						model_valid[set][way] = 1'b0;

					default: ;
				endcase
				e.rsp_data = line;
			end
		end
		return e;
	endfunction

	task automatic model_reset();
		for (int s = 0; s < `L2_SETS; s++)
		begin
			model_rr[s] = '0;
			for (int w = 0; w < `L2_WAYS; w++)
			begin
				model_valid[s][w] = 1'b0;
				model_dirty[s][w] = 1'b0;
				model_tag[s][w] = '0;
				model_line[s][w] = '0;
			end
		end
	endtask

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		if (actual !== expected)
		begin
			failures++;
			$display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
				$time, name, expected, actual);
			$display("TESTS FAILED");
			$fatal(1, "Stopping at the first wrong value");
		end
	endtask

	// One request per call, driven just after the rising edge
	task automatic issue(input l2req_type_t kind, input line_addr_t address,
		input store_mask_t mask, input cache_line_t data, input logic is_fill,
		input cache_line_t fill_data);
		expect_t e;
		core_id_t core;
		req_id_t id;
		@(posedge clk);
		#2;
		core = core_id_t'($urandom);
		id = req_id_t'($urandom);
		req_valid = 1'b1;
		req_type = kind;
		req_core = core;
		req_id = id;
		req_address = address;
		req_store_mask = mask;
		req_data = data;
		req_is_fill = is_fill;
		req_fill_data = fill_data;
		e = l2_predict(kind, core, id, address, mask, data, is_fill, fill_data);
		e.due = cycle + 32'd2;
		expect_q.push_back(e);
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		#2;
		req_valid = 1'b0;
	endtask

	task automatic wait_for_miss(output line_addr_t address);
		int count;
		count = 0;
		@(negedge clk);
		while (!miss_valid && count < TIMEOUT_CYCLES)
		begin
			@(negedge clk);
			count++;
		end
		if (!miss_valid)
		begin
			$display("Timeout: no miss pulse within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTS FAILED");
			$fatal(1, "Miss wait timed out");
		end
		else
			address = miss_address;
	endtask

	// Wait until every prediction has been compared
	task automatic drain();
		int count;
		count = 0;
		while (check_index < expect_q.size() && count < TIMEOUT_CYCLES)
		begin
			@(negedge clk);
			count++;
		end
		if (check_index < expect_q.size())
		begin
			$display("Timeout: %0d predicted results were never compared",
				expect_q.size() - check_index);
			$display("TESTS FAILED");
			$fatal(1, "Drain wait timed out");
		end
	endtask

	// Outputs are stable at the falling edge; idle cycles must stay quiet
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (check_index < expect_q.size() && expect_q[check_index].due == cycle)
			begin
				due_entry = expect_q[check_index];
				check_index++;
			end
			else
				due_entry = '0;
			check_value("rsp_valid", 128'(due_entry.rsp_valid), 128'(rsp_valid));
			check_value("miss_valid", 128'(due_entry.miss_valid), 128'(miss_valid));
			check_value("wb_valid", 128'(due_entry.wb_valid), 128'(wb_valid));
			if (due_entry.rsp_valid)
			begin
				check_value("rsp_type", 128'(due_entry.rsp_type), 128'(rsp_type));
				check_value("rsp_core", 128'(due_entry.rsp_core), 128'(rsp_core));
				check_value("rsp_id", 128'(due_entry.rsp_id), 128'(rsp_id));
				check_value("rsp_address", 128'(due_entry.rsp_address), 128'(rsp_address));
				check_value("rsp_data", due_entry.rsp_data, rsp_data);
			end
			if (due_entry.miss_valid)
				check_value("miss_address", 128'(due_entry.miss_address), 128'(miss_address));
			if (due_entry.wb_valid)
			begin
				check_value("wb_address", 128'(due_entry.wb_address), 128'(wb_address));
				check_value("wb_data", due_entry.wb_data, wb_data);
			end
		end
	end

	initial
	begin
		line_addr_t addr_a;
		line_addr_t addr_b;
		line_addr_t address;
		int pick;
		l2req_type_t fill_kind;

		void'($urandom(32'h8cd5_c952));
		reset = 1'b1;
		req_valid = 1'b0;
		req_type = L2REQ_LOAD;
		req_core = '0;
		req_id = '0;
		req_address = '0;
		req_store_mask = '0;
		req_data = '0;
		req_is_fill = 1'b0;
		req_fill_data = '0;
		model_reset();
		addr_a = make_address(l2_tag_t'(22'h12), l2_set_t'(4'd3));
		addr_b = make_address(l2_tag_t'(22'h7), l2_set_t'(4'd3));

		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;

		// Cold miss, fill from memory, then a hit
		issue(L2REQ_LOAD, addr_a, '0, '0, 1'b0, '0);
		idle_cycle();
		wait_for_miss(address);
		issue(L2REQ_LOAD, address, '0, '0, 1'b1, random_line());
		idle_cycle();
		drain();
		issue(L2REQ_LOAD, addr_a, '0, '0, 1'b0, '0);
		idle_cycle();
		drain();

		// Store hit merges only masked bytes
		issue(L2REQ_STORE, addr_a, 16'h0ff0, random_line(), 1'b0, '0);
		issue(L2REQ_LOAD, addr_a, '0, '0, 1'b0, '0);
		idle_cycle();
		drain();

		// Back-to-back on one line, relying on forwarding in both arrays
		issue(L2REQ_STORE, addr_a, 16'h000f, random_line(), 1'b0, '0);
		issue(L2REQ_LOAD, addr_a, '0, '0, 1'b0, '0);
		issue(L2REQ_STORE, addr_a, 16'hf000, random_line(), 1'b0, '0);
		issue(L2REQ_LOAD, addr_a, '0, '0, 1'b0, '0);
		issue(L2REQ_STORE, addr_b, 16'h00ff, random_line(), 1'b1, random_line());
		issue(L2REQ_STORE, addr_b, 16'hff00, random_line(), 1'b0, '0);
		issue(L2REQ_LOAD, addr_b, '0, '0, 1'b0, '0);
		idle_cycle();
		drain();

		// Fill one set past capacity; dirty victims leave through writeback
		for (int t = 1; t <= 5; t++)
			issue(L2REQ_STORE, make_address(l2_tag_t'(t), l2_set_t'(4'd5)), 16'h0001,
				random_line(), 1'b1, random_line());
		issue(L2REQ_LOAD, make_address(l2_tag_t'(22'h6), l2_set_t'(4'd5)), '0, '0,
			1'b1, random_line());
		idle_cycle();
		drain();

		// Flush of a dirty hit, repeated flush, then a flush miss
		issue(L2REQ_FLUSH, make_address(l2_tag_t'(22'h3), l2_set_t'(4'd5)), '0, '0, 1'b0, '0);
		issue(L2REQ_FLUSH, make_address(l2_tag_t'(22'h3), l2_set_t'(4'd5)), '0, '0, 1'b0, '0);
		issue(L2REQ_FLUSH, make_address(l2_tag_t'(22'h3ff), l2_set_t'(4'd5)), '0, '0,
			1'b0, '0);
		idle_cycle();
		drain();

		// Invalidates
		issue(L2REQ_DINVALIDATE, addr_a, '0, '0, 1'b0, '0);
		issue(L2REQ_LOAD, addr_a, '0, '0, 1'b0, '0);
		issue(L2REQ_IINVALIDATE, addr_b, '0, '0, 1'b0, '0);
		issue(L2REQ_LOAD, addr_b, '0, '0, 1'b0, '0);
		idle_cycle();
		drain();

		// Random mix over a few sets with more tags than ways
		for (int i = 0; i < RANDOM_REQUESTS; i++)
		begin
			pick = $urandom_range(0, 6);
			address = make_address(l2_tag_t'($urandom_range(0, 5)),
				l2_set_t'($urandom_range(8, 11)));
			fill_kind = ($urandom_range(0, 1) == 0) ? L2REQ_LOAD : L2REQ_STORE;
			// A fill for a line already held is not legal
			if (pick == 6 && line_present(address))
				pick = 1;
			case (pick)
				0: idle_cycle();
				1: issue(L2REQ_LOAD, address, '0, '0, 1'b0, '0);
				2: issue(L2REQ_STORE, address, store_mask_t'($urandom), random_line(),
					1'b0, '0);
				3: issue(L2REQ_FLUSH, address, '0, '0, 1'b0, '0);
				4: issue(L2REQ_DINVALIDATE, address, '0, '0, 1'b0, '0);
				5: issue(L2REQ_IINVALIDATE, address, '0, '0, 1'b0, '0);
				default: issue(fill_kind, address, store_mask_t'($urandom), random_line(),
					1'b1, random_line());
			endcase
		end
		idle_cycle();
		drain();

		// Quiet tail, no stray pulses
		repeat (4) @(negedge clk);
		if (failures == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
